// ==== hw/glb_store_consts.svh ====
/*
 * widths and sizes for the two-channel store path
 * a single bank of 128 words of 64 bits is assumed
 * GLB_SHIFT_DEPTH must exceed max cfg_latency plus GLB_FIXED_LATENCY
 */
`ifndef GLB_STORE_CONSTS_SVH
`define GLB_STORE_CONSTS_SVH

// fabric and bank word widths
`define GLB_CGRA_DATA_WIDTH      16
`define GLB_BANK_DATA_WIDTH      64

// byte address, low bits dropped for a bank word index
`define GLB_ADDR_WIDTH           10
`define GLB_BANK_BYTE_OFFSET     3

// header queue and burst length
`define GLB_QUEUE_DEPTH          2
`define GLB_MAX_NUM_WORDS_WIDTH  8

// done pulse delay
`define GLB_LATENCY_WIDTH        3
`define GLB_FIXED_LATENCY        2
`define GLB_SHIFT_DEPTH          10

`endif

// ==== hw/glb_store_pkg.sv ====
/*
 * shared types of the store path
 * bank words are built from four 16-bit lanes, lane 0 in the low bits
 */
`include "glb_store_consts.svh"

package glb_store_pkg;

    // one entry of the store header queue
    typedef struct packed {
        logic                                valid;
        logic [`GLB_ADDR_WIDTH-1:0]          start_addr;
        logic [`GLB_MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_st_header_t;

    typedef struct packed {
        logic [`GLB_CGRA_DATA_WIDTH-1:0] data;
        logic                            valid;
    } stream_word_t;

    // filled lane by lane, stored as one raw word
    typedef union packed {
        logic [`GLB_BANK_DATA_WIDTH-1:0] raw;
        logic [`GLB_BANK_DATA_WIDTH/`GLB_CGRA_DATA_WIDTH-1:0][`GLB_CGRA_DATA_WIDTH-1:0] lanes;
    } bank_word_u;

    typedef struct packed {
        logic                              wr_en;
        logic [`GLB_BANK_DATA_WIDTH/8-1:0] wr_strb;
        logic [`GLB_ADDR_WIDTH-1:0]        wr_addr;
        bank_word_u                        wr_data;
    } wr_packet_t;

    typedef enum logic [1:0] {
        mode_off      = 2'b00,
        mode_manual   = 2'b01,
        mode_reserved = 2'b10,
        mode_auto     = 2'b11
    } dma_mode_e;

endpackage

// ==== hw/glb_shift.sv ====
/*
 * single-bit delay line, tap k is data_in delayed by k+1 cycles
 * all taps hold while clk_en is low
 */
module glb_shift #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic clk_en,
    input  logic data_in,
    output logic data_out [DEPTH]
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                data_out[i] <= 1'b0;
            end
        end else if (clk_en) begin
            data_out[0] <= data_in;
            // each tap takes the one before it
            for (int i = 1; i < DEPTH; i++) begin
                data_out[i] <= data_out[i-1];
            end
        end
    end

endmodule

// ==== hw/glb_store_dma.sv ====
/*
 * store DMA channel, packs 16-bit stream words into 64-bit bank writes
 * no back-pressure: one stream word is taken per enabled cycle
 * headers with num_words of zero are never launched and stall the queue
 * done_pulse follows the done state by cfg_latency + 3 cycles
 */
`include "glb_store_consts.svh"

module glb_store_dma (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  glb_store_pkg::stream_word_t     stream_f2g,
    input  glb_store_pkg::dma_mode_e        cfg_mode,
    input  glb_store_pkg::dma_st_header_t   cfg_header [`GLB_QUEUE_DEPTH],
    input  logic [`GLB_LATENCY_WIDTH-1:0]   cfg_latency,
    output glb_store_pkg::wr_packet_t       wr_packet,
    output logic                            invalidate_pulse [`GLB_QUEUE_DEPTH],
    output logic                            done_pulse
);

    import glb_store_pkg::*;

    typedef enum logic [2:0] {
        st_off, st_idle, st_lane0, st_lane1, st_lane2, st_lane3, st_full, st_done
    } dma_state_e;

    dma_state_e state, next_state;

    logic dma_on;
    logic auto_on;

    // registered stream word
    logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data_d1;
    logic                            stream_valid_d1;

    // header queue
    dma_st_header_t header_int [`GLB_QUEUE_DEPTH];
    logic           header_valid_d1 [`GLB_QUEUE_DEPTH];
    logic [$clog2(`GLB_QUEUE_DEPTH)-1:0] q_sel_r, q_sel;
    dma_st_header_t cur_header;
    logic           launch;

    // packing state
    bank_word_u                          cache, next_cache;
    logic [`GLB_BANK_DATA_WIDTH/8-1:0]   strb, next_strb;
    logic [`GLB_ADDR_WIDTH-1:0]          cur_addr, next_cur_addr;
    logic [`GLB_MAX_NUM_WORDS_WIDTH-1:0] num_cnt, next_num_cnt;
    logic                                first_word, next_first_word;
    logic [1:0]                          lane_sel;
    logic                                take_word;

    // done pulse delay
    logic                          done_rise;
    logic                          done_shift [`GLB_SHIFT_DEPTH];
    logic [`GLB_LATENCY_WIDTH:0]   done_tap;

    assign dma_on  = (cfg_mode != mode_off);
    assign auto_on = (cfg_mode == mode_auto);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stream_valid_d1 <= 1'b0;
        end else if (clk_en) begin
            stream_valid_d1 <= stream_f2g.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            stream_data_d1 <= stream_f2g.data;
        end
    end

    // manual mode always serves entry 0
    assign q_sel      = auto_on ? q_sel_r : '0;
    assign cur_header = header_int[q_sel];
    assign launch     = (state == st_idle) && cur_header.valid && (cur_header.num_words != '0);

    // capture on rising valid, drop the entry once launched
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                header_int[i]       <= '0;
                header_valid_d1[i]  <= 1'b0;
                invalidate_pulse[i] <= 1'b0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                header_valid_d1[i]  <= cfg_header[i].valid;
                invalidate_pulse[i] <= launch && (q_sel == i);
                if (cfg_header[i].valid && !header_valid_d1[i]) begin
                    header_int[i] <= cfg_header[i];
                end else if (launch && (q_sel == i)) begin
                    header_int[i].valid <= 1'b0;
                end
            end
        end
    end

    // round-robin pointer, advances on each launch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel_r <= '0;
        end else if (clk_en) begin
            if (!auto_on) begin
                q_sel_r <= '0;
            end else if (launch) begin
                q_sel_r <= (q_sel_r == `GLB_QUEUE_DEPTH - 1) ? '0 : q_sel_r + 1'b1;
            end
        end
    end

    assign lane_sel  = (state == st_full) ? 2'd0 : 2'(state - st_lane0);
    assign take_word = (state inside {st_lane0, st_lane1, st_lane2, st_lane3, st_full})
                       && (num_cnt != '0) && stream_valid_d1;

    always_comb begin
        next_state      = state;
        next_cache      = cache;
        next_strb       = strb;
        next_cur_addr   = cur_addr;
        next_num_cnt    = num_cnt;
        next_first_word = first_word;
        case (state)
            st_off: begin
                next_strb = '0;
                if (dma_on) begin
                    next_state = st_idle;
                end
            end
            st_idle: begin
                if (launch) begin
                    next_cur_addr   = cur_header.start_addr;
                    next_num_cnt    = cur_header.num_words;
                    next_first_word = 1'b1;
                    // address bits 2:1 pick the first lane
                    next_state = dma_state_e'(st_lane0 + 3'(cur_header.start_addr[2:1]));
                end
            end
            st_lane0, st_lane1, st_lane2, st_lane3: begin
                if (num_cnt == '0) begin
                    next_state = st_done;
                end else if (stream_valid_d1) begin
                    next_state = dma_state_e'(state + 3'd1);
                end
            end
            st_full: begin
                // the full word leaves this cycle, start a fresh cache
                next_cache.raw = '0;
                next_strb      = '0;
                if (num_cnt == '0) begin
                    next_cache = cache;
                    next_strb  = strb;
                    next_state = st_done;
                end else if (stream_valid_d1) begin
                    next_state = st_lane1;
                end else begin
                    next_state = st_lane0;
                end
            end
            st_done: begin
                next_strb    = '0;
                next_num_cnt = '0;
                next_state   = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase

        if (take_word) begin
            next_cache.lanes[lane_sel]    = stream_data_d1;
            next_strb[{lane_sel, 1'b0} +: 2] = 2'b11;
            next_num_cnt    = num_cnt - 1'b1;
            next_first_word = 1'b0;
            if (!first_word) begin
                next_cur_addr = cur_addr + `GLB_ADDR_WIDTH'(`GLB_CGRA_DATA_WIDTH / 8);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_off;
            strb       <= '0;
            cur_addr   <= '0;
            num_cnt    <= '0;
            first_word <= 1'b0;
        end else if (clk_en) begin
            state      <= dma_on ? next_state : st_off;
            strb       <= next_strb;
            cur_addr   <= next_cur_addr;
            num_cnt    <= next_num_cnt;
            first_word <= next_first_word;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            cache <= next_cache;
        end
    end

    // full word mid-burst, or the last partial word at the end
    always_comb begin
        wr_packet = '0;
        if ((state == st_done) || ((state == st_full) && (num_cnt != '0))) begin
            wr_packet.wr_en   = 1'b1;
            wr_packet.wr_strb = strb;
            wr_packet.wr_data = cache;
            wr_packet.wr_addr = {cur_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET],
                                 {`GLB_BANK_BYTE_OFFSET{1'b0}}};
        end
    end

    // done lasts a single enabled cycle, so the state itself marks the edge
    assign done_rise = (state == st_done);

    glb_shift #(
        .DEPTH(`GLB_SHIFT_DEPTH)
    ) done_delay (
        .clk     (clk),
        .reset   (reset),
        .clk_en  (clk_en),
        .data_in (done_rise),
        .data_out(done_shift)
    );

    assign done_tap   = {1'b0, cfg_latency} + (`GLB_LATENCY_WIDTH+1)'(`GLB_FIXED_LATENCY);
    assign done_pulse = done_shift[done_tap];

endmodule

// ==== hw/glb_bank_writer.sv ====
/*
 * single bank of 128 x 64-bit words, cleared by reset
 * two write ports applied per cycle under byte strobes
 * channel 1 wins on a byte both channels write in one cycle
 * read port is combinational, indexed by bank word
 */
`include "glb_store_consts.svh"

module glb_bank_writer (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  glb_store_pkg::wr_packet_t                              wr_packet_0,
    input  glb_store_pkg::wr_packet_t                              wr_packet_1,
    input  logic [`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0]       rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]                        rd_data
);

    logic [`GLB_BANK_DATA_WIDTH-1:0] mem [1 << (`GLB_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET)];

    // bank word index of each write
    logic [`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0] wr_idx_0;
    logic [`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0] wr_idx_1;

    assign wr_idx_0 = wr_packet_0.wr_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET];
    assign wr_idx_1 = wr_packet_1.wr_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < (1 << (`GLB_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET)); w++) begin
                mem[w] <= '0;
            end
        end else begin
            if (wr_packet_0.wr_en) begin
                for (int b = 0; b < `GLB_BANK_DATA_WIDTH / 8; b++) begin
                    if (wr_packet_0.wr_strb[b]) begin
                        mem[wr_idx_0][b*8 +: 8] <= wr_packet_0.wr_data.raw[b*8 +: 8];
                    end
                end
            end
            // later assignment, so channel 1 takes priority
            if (wr_packet_1.wr_en) begin
                for (int b = 0; b < `GLB_BANK_DATA_WIDTH / 8; b++) begin
                    if (wr_packet_1.wr_strb[b]) begin
                        mem[wr_idx_1][b*8 +: 8] <= wr_packet_1.wr_data.raw[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

// ==== hw/glb_store_top.sv ====
/*
 * two store DMA channels sharing one bank
 * headers are driven straight from ports, no register file
 * rd_addr is a bank word index, not a byte address
 */
`include "glb_store_consts.svh"

module glb_store_top (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              clk_en,
    input  glb_store_pkg::stream_word_t                       stream_f2g_0,
    input  glb_store_pkg::stream_word_t                       stream_f2g_1,
    input  glb_store_pkg::dma_mode_e                          cfg_mode_0,
    input  glb_store_pkg::dma_mode_e                          cfg_mode_1,
    input  glb_store_pkg::dma_st_header_t                     cfg_header_0 [`GLB_QUEUE_DEPTH],
    input  glb_store_pkg::dma_st_header_t                     cfg_header_1 [`GLB_QUEUE_DEPTH],
    input  logic [`GLB_LATENCY_WIDTH-1:0]                     cfg_latency_0,
    input  logic [`GLB_LATENCY_WIDTH-1:0]                     cfg_latency_1,
    output logic                                              invalidate_pulse_0 [`GLB_QUEUE_DEPTH],
    output logic                                              invalidate_pulse_1 [`GLB_QUEUE_DEPTH],
    output logic                                              done_pulse_0,
    output logic                                              done_pulse_1,
    input  logic [`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0]  rd_addr,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]                   rd_data
);

    import glb_store_pkg::*;

    wr_packet_t wr_packet_0;
    wr_packet_t wr_packet_1;

    glb_store_dma dma_0 (
        .clk             (clk),
        .reset           (reset),
        .clk_en          (clk_en),
        .stream_f2g      (stream_f2g_0),
        .cfg_mode        (cfg_mode_0),
        .cfg_header      (cfg_header_0),
        .cfg_latency     (cfg_latency_0),
        .wr_packet       (wr_packet_0),
        .invalidate_pulse(invalidate_pulse_0),
        .done_pulse      (done_pulse_0)
    );

    glb_store_dma dma_1 (
        .clk             (clk),
        .reset           (reset),
        .clk_en          (clk_en),
        .stream_f2g      (stream_f2g_1),
        .cfg_mode        (cfg_mode_1),
        .cfg_header      (cfg_header_1),
        .cfg_latency     (cfg_latency_1),
        .wr_packet       (wr_packet_1),
        .invalidate_pulse(invalidate_pulse_1),
        .done_pulse      (done_pulse_1)
    );

    glb_bank_writer bank (
        .clk        (clk),
        .reset      (reset),
        .wr_packet_0(wr_packet_0),
        .wr_packet_1(wr_packet_1),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

// ==== verif/tb_glb_store.sv ====
/*
 * testbench for the two-channel store path
 * runs a case table of headers and streams, checks bank read-back
 * against a byte model and counts invalidate and done pulses
 * start addresses in the table are expected to be even
 */
`include "glb_store_consts.svh"

module tb_glb_store;

    timeunit 1ns;
    timeprecision 100ps;

    import glb_store_pkg::*;

    localparam int bank_words   = 1 << (`GLB_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET);
    localparam int wait_limit   = 200;
    localparam int quiet_cycles = 40;
    localparam int stray_words  = 4;
    localparam int kind_done    = 2;
    localparam int num_cases    = 7;

    // chan 2 means both channels, addr_b feeds channel 1 or the second auto header
    typedef struct packed {
        logic [1:0]                          chan;
        dma_mode_e                           mode;
        logic [`GLB_ADDR_WIDTH-1:0]          addr_a;
        logic [`GLB_ADDR_WIDTH-1:0]          addr_b;
        logic [`GLB_MAX_NUM_WORDS_WIDTH-1:0] num_words;
        logic [31:0]                         seed;
        logic                                gap;
    } test_case_t;

    test_case_t cases [num_cases] = '{
        '{2'd0, mode_manual, 10'h000, 10'h000, 8'd8,  32'h0000_1111, 1'b0},
        '{2'd0, mode_manual, 10'h002, 10'h000, 8'd5,  32'h0000_2222, 1'b0},
        '{2'd1, mode_manual, 10'h00e, 10'h000, 8'd3,  32'h0000_3333, 1'b1},
        '{2'd0, mode_auto,   10'h040, 10'h080, 8'd6,  32'h0000_4444, 1'b0},
        '{2'd2, mode_manual, 10'h100, 10'h146, 8'd11, 32'h0000_5555, 1'b1},
        '{2'd1, mode_off,    10'h200, 10'h000, 8'd4,  32'h0000_6666, 1'b0},
        '{2'd0, mode_manual, 10'h240, 10'h000, 8'd0,  32'h0000_7777, 1'b0}
    };

    logic                                           clk;
    logic                                           reset;
    logic                                           clk_en;
    stream_word_t                                   stream_f2g_0;
    stream_word_t                                   stream_f2g_1;
    dma_mode_e                                      cfg_mode_0;
    dma_mode_e                                      cfg_mode_1;
    dma_st_header_t                                 cfg_header_0 [`GLB_QUEUE_DEPTH];
    dma_st_header_t                                 cfg_header_1 [`GLB_QUEUE_DEPTH];
    logic [`GLB_LATENCY_WIDTH-1:0]                  cfg_latency_0;
    logic [`GLB_LATENCY_WIDTH-1:0]                  cfg_latency_1;
    logic                                           invalidate_pulse_0 [`GLB_QUEUE_DEPTH];
    logic                                           invalidate_pulse_1 [`GLB_QUEUE_DEPTH];
    logic                                           done_pulse_0;
    logic                                           done_pulse_1;
    logic [`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0] rd_addr;
    logic [`GLB_BANK_DATA_WIDTH-1:0]                rd_data;

    // byte image of the bank
    logic [7:0]  model_mem [1 << `GLB_ADDR_WIDTH];
    logic [31:0] data_state [2];
    logic [31:0] gap_state;

    int errors;
    int checks;
    int cycle;
    int done_cnt [2];
    int inv_cnt [2][`GLB_QUEUE_DEPTH];
    int inv_at [2][`GLB_QUEUE_DEPTH];

    glb_store_top uut (
        .clk               (clk),
        .reset             (reset),
        .clk_en            (clk_en),
        .stream_f2g_0      (stream_f2g_0),
        .stream_f2g_1      (stream_f2g_1),
        .cfg_mode_0        (cfg_mode_0),
        .cfg_mode_1        (cfg_mode_1),
        .cfg_header_0      (cfg_header_0),
        .cfg_header_1      (cfg_header_1),
        .cfg_latency_0     (cfg_latency_0),
        .cfg_latency_1     (cfg_latency_1),
        .invalidate_pulse_0(invalidate_pulse_0),
        .invalidate_pulse_1(invalidate_pulse_1),
        .done_pulse_0      (done_pulse_0),
        .done_pulse_1      (done_pulse_1),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // pulse counters, sampled mid-cycle
    always @(negedge clk) begin
        cycle++;
        for (int e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
            if (invalidate_pulse_0[e]) begin
                inv_cnt[0][e]++;
                inv_at[0][e] = cycle;
            end
            if (invalidate_pulse_1[e]) begin
                inv_cnt[1][e]++;
                inv_at[1][e] = cycle;
            end
        end
        if (done_pulse_0) begin
            done_cnt[0]++;
        end
        if (done_pulse_1) begin
            done_cnt[1]++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pulse_count(input int c, input int kind);
        if (kind == kind_done) begin
            return done_cnt[c];
        end
        return inv_cnt[c][kind];
    endfunction

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic step_to_drive();
        @(posedge clk);
        #10;
    endtask

    task automatic set_channel(input int c, input dma_mode_e mode,
                               input dma_st_header_t h0, input dma_st_header_t h1);
        if (c == 0) begin
            cfg_mode_0      = mode;
            cfg_header_0[0] = h0;
            cfg_header_0[1] = h1;
        end else begin
            cfg_mode_1      = mode;
            cfg_header_1[0] = h0;
            cfg_header_1[1] = h1;
        end
    endtask

    task automatic drop_headers();
        step_to_drive();
        for (int e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
            cfg_header_0[e].valid = 1'b0;
            cfg_header_1[e].valid = 1'b0;
        end
    endtask

    task automatic wait_pulses(input int c, input int kind, input int target);
        int n;
        n = 0;
        while ((pulse_count(c, kind) < target) && (n < wait_limit)) begin
            @(posedge clk);
            n++;
        end
        if (pulse_count(c, kind) < target) begin
            errors++;
            if (kind == kind_done) begin
                $display("channel %0d timed out waiting for its done pulse", c);
            end else begin
                $display("channel %0d timed out waiting for invalidate on entry %0d", c, kind);
            end
        end
    endtask

    // word i of a burst lands at byte start + 2i, low byte first
    // words streamed with no launched header leave the model alone
    task automatic stream_bursts(input logic [1:0] active,
                                 input logic [`GLB_ADDR_WIDTH-1:0] addr_0,
                                 input logic [`GLB_ADDR_WIDTH-1:0] addr_1,
                                 input int num_words, input logic gap,
                                 input logic to_model);
        int           sent [2];
        int           byte_addr;
        stream_word_t word;
        sent[0] = active[0] ? 0 : num_words;
        sent[1] = active[1] ? 0 : num_words;
        while ((sent[0] < num_words) || (sent[1] < num_words)) begin
            step_to_drive();
            for (int c = 0; c < 2; c++) begin
                word = '0;
                gap_state = xorshift32(gap_state);
                if ((sent[c] < num_words) && !(gap && (gap_state[1:0] == 2'b00))) begin
                    data_state[c] = xorshift32(data_state[c]);
                    word.data  = data_state[c][15:0];
                    word.valid = 1'b1;
                    byte_addr  = ((c == 0) ? int'(addr_0) : int'(addr_1)) + 2 * sent[c];
                    if (to_model) begin
                        model_mem[byte_addr]     = word.data[7:0];
                        model_mem[byte_addr + 1] = word.data[15:8];
                    end
                    sent[c]++;
                end
                if (c == 0) begin
                    stream_f2g_0 = word;
                end else begin
                    stream_f2g_1 = word;
                end
            end
        end
        step_to_drive();
        stream_f2g_0 = '0;
        stream_f2g_1 = '0;
    endtask

    task automatic check_bank();
        logic [63:0] expected;
        for (int w = 0; w < bank_words; w++) begin
            step_to_drive();
            rd_addr = w[`GLB_ADDR_WIDTH-`GLB_BANK_BYTE_OFFSET-1:0];
            @(negedge clk);
            for (int b = 0; b < 8; b++) begin
                expected[b*8 +: 8] = model_mem[w*8 + b];
            end
            compare($sformatf("rd_data[%0d]", w), rd_data, expected);
        end
    endtask

    task automatic run_case(input test_case_t tc);
        logic [1:0]                 active;
        logic                       auto_mode;
        logic                       launches;
        int                         bursts;
        int                         base_done [2];
        int                         base_inv [2][`GLB_QUEUE_DEPTH];
        logic [`GLB_ADDR_WIDTH-1:0] addr_1;
        dma_st_header_t             h0;
        dma_st_header_t             h1;

        active    = (tc.chan == 2'd2) ? 2'b11 : (2'b01 << tc.chan);
        auto_mode = (tc.mode == mode_auto);
        launches  = (tc.mode != mode_off) && (tc.num_words != '0);
        bursts    = !launches ? 0 : (auto_mode ? 2 : 1);
        addr_1    = (tc.chan == 2'd2) ? tc.addr_b : tc.addr_a;
        for (int c = 0; c < 2; c++) begin
            base_done[c] = done_cnt[c];
            for (int e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
                base_inv[c][e] = inv_cnt[c][e];
            end
        end
        data_state[0] = xorshift32(32'hb4dd_170f ^ tc.seed);
        data_state[1] = xorshift32(32'hb4dd_170f ^ ~tc.seed);

        step_to_drive();
        h1 = '{valid: auto_mode, start_addr: tc.addr_b, num_words: tc.num_words};
        if (active[0]) begin
            h0 = '{valid: 1'b1, start_addr: tc.addr_a, num_words: tc.num_words};
            set_channel(0, tc.mode, h0, h1);
        end
        if (active[1]) begin
            h0 = '{valid: 1'b1, start_addr: addr_1, num_words: tc.num_words};
            set_channel(1, tc.mode, h0, h1);
        end

        if (launches) begin
            for (int c = 0; c < 2; c++) begin
                if (active[c]) begin
                    wait_pulses(c, 0, base_inv[c][0] + 1);
                end
            end
            stream_bursts(active, tc.addr_a, addr_1, int'(tc.num_words), tc.gap, 1'b1);
            if (auto_mode) begin
                for (int c = 0; c < 2; c++) begin
                    if (active[c]) begin
                        wait_pulses(c, 1, base_inv[c][1] + 1);
                    end
                end
                stream_bursts(active, tc.addr_b, tc.addr_b, int'(tc.num_words), tc.gap, 1'b1);
            end
            for (int c = 0; c < 2; c++) begin
                if (active[c]) begin
                    wait_pulses(c, kind_done, base_done[c] + bursts);
                end
            end
        end else begin
            // feed words anyway, none of them may reach the bank
            stream_bursts(active, tc.addr_a, addr_1, stray_words, tc.gap, 1'b0);
            repeat (quiet_cycles) @(posedge clk);
        end

        drop_headers();
        check_bank();

        for (int c = 0; c < 2; c++) begin
            compare($sformatf("done_pulse_%0d count", c),
                    64'(done_cnt[c] - base_done[c]), active[c] ? 64'(bursts) : 64'd0);
            compare($sformatf("invalidate_pulse_%0d[0] count", c),
                    64'(inv_cnt[c][0] - base_inv[c][0]), 64'(active[c] && launches));
            compare($sformatf("invalidate_pulse_%0d[1] count", c),
                    64'(inv_cnt[c][1] - base_inv[c][1]),
                    64'(active[c] && launches && auto_mode));
            if (active[c] && launches && auto_mode) begin
                compare($sformatf("invalidate_pulse_%0d entry order", c),
                        64'(inv_at[c][0] < inv_at[c][1]), 64'd1);
            end
        end
    endtask

    initial begin
        reset         = 1'b1;
        clk_en        = 1'b1;
        stream_f2g_0  = '0;
        stream_f2g_1  = '0;
        cfg_mode_0    = mode_off;
        cfg_mode_1    = mode_off;
        cfg_latency_0 = 3'd3;
        cfg_latency_1 = 3'd5;
        rd_addr       = '0;
        gap_state     = 32'hb4dd_170f;
        for (int e = 0; e < `GLB_QUEUE_DEPTH; e++) begin
            cfg_header_0[e] = '0;
            cfg_header_1[e] = '0;
        end
        // bank comes out of reset cleared
        for (int i = 0; i < (1 << `GLB_ADDR_WIDTH); i++) begin
            model_mem[i] = 8'h00;
        end

        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        for (int i = 0; i < num_cases; i++) begin
            run_case(cases[i]);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/glb_store_pkg.sv
hw/glb_shift.sv
hw/glb_store_dma.sv
hw/glb_bank_writer.sv
hw/glb_store_top.sv
verif/tb_glb_store.sv

// ==== Makefile ====
# Verilator build for the store path testbench

VERILATOR  ?= verilator
TOP        ?= tb_glb_store
FILE_LIST  ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
